// File: hw/cic_decimator.sv
// Integrate-and-dump decimator
`timescale 1ns/1ns
`default_nettype none

module cic_decimator (
  input  logic               i_ce_clk,
  input  logic               i_rst,
  input  logic [7:0]         i_decim,
  input  logic               i_valid,
  input  ddc_pkg::iq_beat_t  i_beat,
  output logic               o_ready,
  output logic               o_valid,
  output ddc_pkg::acc_beat_t o_beat,
  input  logic               i_ready
);

  localparam int EXT_W = ddc_pkg::ACC_W - ddc_pkg::SAMPLE_W;

  logic [7:0]                     count_q;
  logic [7:0]                     decim_q;
  logic [7:0]                     cur_decim;
  logic signed [ddc_pkg::ACC_W-1:0] acc_i_q;
  logic signed [ddc_pkg::ACC_W-1:0] acc_q_q;
  logic                           accept;
  logic                           close;
  ddc_pkg::acc_beat_t             sum;

  // Rate is captured when a group opens
  assign cur_decim = (count_q == 8'd0) ? i_decim : decim_q;
  assign close     = i_beat.last || ({1'b0, count_q} + 9'd1 >= {1'b0, cur_decim});
  assign accept    = i_valid & o_ready;

  assign sum.s.i  = acc_i_q + {{EXT_W{i_beat.s.i[15]}}, i_beat.s.i};
  assign sum.s.q  = acc_q_q + {{EXT_W{i_beat.s.q[15]}}, i_beat.s.q};
  assign sum.last = i_beat.last;

  ////////////////////
  // Integrator
  ////////////////////
  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      count_q <= 8'd0;
      decim_q <= 8'd1;
      acc_i_q <= '0;
      acc_q_q <= '0;
    end else if (accept) begin
      if (count_q == 8'd0) begin
        decim_q <= i_decim;
      end
      if (close) begin
        // Dump and start the next group empty
        count_q <= 8'd0;
        acc_i_q <= '0;
        acc_q_q <= '0;
      end else begin
        count_q <= count_q + 8'd1;
        acc_i_q <= sum.s.i;
        acc_q_q <= sum.s.q;
      end
    end
  end

  // Only a closing beat produces output
  stream_reg #(.T(ddc_pkg::acc_beat_t)) u_out_reg (
    .i_ce_clk (i_ce_clk),
    .i_rst    (i_rst),
    .i_valid  (i_valid & close),
    .i_data   (sum),
    .o_ready  (o_ready),
    .o_valid  (o_valid),
    .o_data   (o_beat),
    .i_ready  (i_ready)
  );

  a_count_range : assert property (@(posedge i_ce_clk) disable iff (i_rst)
    (count_q != 8'd0) |-> (count_q < decim_q));

endmodule

`default_nettype wire

// File: hw/ddc_block.sv
// Two-channel DDC top level
`timescale 1ns/1ns
`default_nettype none

module ddc_block (
  input  logic                                           i_ce_clk,
  input  logic                                           i_rst,
  input  logic                                           i_set_stb,
  input  ddc_pkg::setting_t                              i_set,
  input  logic                                           i_rb_stb,
  input  ddc_pkg::rb_req_t                               i_rb_req,
  output logic                                           o_rb_valid,
  output logic [63:0]                                    o_rb_data,
  input  logic [ddc_pkg::NUM_CHAINS-1:0]                 i_in_valid,
  input  ddc_pkg::iq_beat_t [ddc_pkg::NUM_CHAINS-1:0]    i_in_beat,
  output logic [ddc_pkg::NUM_CHAINS-1:0]                 o_in_ready,
  output logic [ddc_pkg::NUM_CHAINS-1:0]                 o_out_valid,
  output ddc_pkg::iq_beat_t [ddc_pkg::NUM_CHAINS-1:0]    o_out_beat,
  input  logic [ddc_pkg::NUM_CHAINS-1:0]                 i_out_ready
);

  logic [ddc_pkg::NUM_CHAINS-1:0][63:0] chain_rb;
  logic                                 rb_valid_q;
  logic [63:0]                          rb_data_q;

  for (genvar c = 0; c < ddc_pkg::NUM_CHAINS; c++) begin : gen_chain
    ddc_chain #(.CHAIN_IDX(c)) u_chain (
      .i_ce_clk    (i_ce_clk),
      .i_rst       (i_rst),
      .i_set_stb   (i_set_stb),
      .i_set       (i_set),
      .i_rb_addr   (i_rb_req.addr),
      .o_rb_data   (chain_rb[c]),
      .i_in_valid  (i_in_valid[c]),
      .i_in_beat   (i_in_beat[c]),
      .o_in_ready  (o_in_ready[c]),
      .o_out_valid (o_out_valid[c]),
      .o_out_beat  (o_out_beat[c]),
      .i_out_ready (i_out_ready[c])
    );
  end

  // Readback answers one cycle after the strobe
  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      rb_valid_q <= 1'b0;
    end else begin
      rb_valid_q <= i_rb_stb;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (i_rb_stb) begin
      rb_data_q <= chain_rb[i_rb_req.chan];
    end
  end

  assign o_rb_valid = rb_valid_q;
  assign o_rb_data  = rb_data_q;

  a_rb_single : assert property (@(posedge i_ce_clk) disable iff (i_rst)
    o_rb_valid |=> !o_rb_valid);

endmodule

`default_nettype wire

// File: hw/ddc_chain.sv
// One DDC channel
`timescale 1ns/1ns
`default_nettype none

module ddc_chain #(
  parameter int CHAIN_IDX = 0
) (
  input  logic              i_ce_clk,
  input  logic              i_rst,
  input  logic              i_set_stb,
  input  ddc_pkg::setting_t i_set,
  input  logic [7:0]        i_rb_addr,
  output logic [63:0]       o_rb_data,
  input  logic              i_in_valid,
  input  ddc_pkg::iq_beat_t i_in_beat,
  output logic              o_in_ready,
  output logic              o_out_valid,
  output ddc_pkg::iq_beat_t o_out_beat,
  input  logic              i_out_ready
);

  ddc_pkg::chain_cfg_t cfg;

  logic               mix_valid;
  logic               mix_ready;
  ddc_pkg::iq_beat_t  mix_beat;
  logic               cic_valid;
  logic               cic_ready;
  ddc_pkg::acc_beat_t cic_beat;

  ddc_settings #(.CHAIN_IDX(CHAIN_IDX)) u_settings (
    .i_ce_clk  (i_ce_clk),
    .i_rst     (i_rst),
    .i_set_stb (i_set_stb),
    .i_set     (i_set),
    .i_rb_addr (i_rb_addr),
    .o_cfg     (cfg),
    .o_rb_data (o_rb_data)
  );

  ////////////////////
  // Sample path
  ////////////////////
  quadrant_mixer u_mixer (
    .i_ce_clk (i_ce_clk),
    .i_rst    (i_rst),
    .i_freq   (cfg.freq),
    .i_valid  (i_in_valid),
    .i_beat   (i_in_beat),
    .o_ready  (o_in_ready),
    .o_valid  (mix_valid),
    .o_beat   (mix_beat),
    .i_ready  (mix_ready)
  );

  cic_decimator u_cic (
    .i_ce_clk (i_ce_clk),
    .i_rst    (i_rst),
    .i_decim  (cfg.decim),
    .i_valid  (mix_valid),
    .i_beat   (mix_beat),
    .o_ready  (mix_ready),
    .o_valid  (cic_valid),
    .o_beat   (cic_beat),
    .i_ready  (cic_ready)
  );

  iq_scaler u_scaler (
    .i_ce_clk (i_ce_clk),
    .i_rst    (i_rst),
    .i_scale  (cfg.scale),
    .i_valid  (cic_valid),
    .i_beat   (cic_beat),
    .o_ready  (cic_ready),
    .o_valid  (o_out_valid),
    .o_beat   (o_out_beat),
    .i_ready  (i_out_ready)
  );

endmodule

`default_nettype wire

// File: hw/ddc_pkg.sv
// DDC shared types and constants
`default_nettype none

package ddc_pkg;

  ////////////////////
  // Sizes
  ////////////////////
  localparam int NUM_CHAINS    = 2;
  localparam int SAMPLE_W      = 16;
  localparam int SCALE_W       = 18;
  localparam int ACC_W         = 24;
  localparam int PROD_W        = ACC_W + SCALE_W;
  localparam int SCALE_SHIFT   = 15;
  localparam int CIC_MAX_DECIM = 255;

  // Settings bus register map in the user space above 128
  localparam logic [7:0] SR_FREQ_ADDR     = 8'd132;
  localparam logic [7:0] SR_SCALE_IQ_ADDR = 8'd133;
  localparam logic [7:0] SR_DECIM_ADDR    = 8'd134;

  // Readback map
  localparam logic [7:0] RB_COMPAT_NUM    = 8'd0;
  localparam logic [7:0] RB_CIC_MAX_DECIM = 8'd2;
  localparam logic [7:0] RB_FREQ          = 8'd3;
  localparam logic [7:0] RB_DECIM         = 8'd4;

  localparam logic [63:0] COMPAT_NUM = {32'h2, 32'h0};
  localparam logic [63:0] RB_DEFAULT = 64'h0BADC0DE0BADC0DE;

  // Gain of exactly one with SCALE_SHIFT of 15
  localparam logic signed [SCALE_W-1:0] SCALE_UNITY = 18'sd32768;

  localparam logic signed [SAMPLE_W-1:0] SAMPLE_MAX = 16'sh7FFF;
  localparam logic signed [SAMPLE_W-1:0] SAMPLE_MIN = 16'sh8000;

  ////////////////////
  // Types
  ////////////////////
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] i;
    logic signed [SAMPLE_W-1:0] q;
  } sample_t;

  typedef struct packed {
    sample_t s;
    logic    last;
  } iq_beat_t;

  typedef struct packed {
    logic signed [ACC_W-1:0] i;
    logic signed [ACC_W-1:0] q;
  } acc_sample_t;

  typedef struct packed {
    acc_sample_t s;
    logic        last;
  } acc_beat_t;

  typedef struct packed {
    logic        chan;
    logic [7:0]  addr;
    logic [31:0] data;
  } setting_t;

  typedef struct packed {
    logic       chan;
    logic [7:0] addr;
  } rb_req_t;

  typedef struct packed {
    logic [31:0]               freq;
    logic signed [SCALE_W-1:0] scale;
    logic [7:0]                decim;
  } chain_cfg_t;

endpackage

`default_nettype wire

// File: hw/ddc_settings.sv
// Per-channel settings and readback
`timescale 1ns/1ns
`default_nettype none

module ddc_settings #(
  parameter int CHAIN_IDX = 0
) (
  input  logic                 i_ce_clk,
  input  logic                 i_rst,
  input  logic                 i_set_stb,
  input  ddc_pkg::setting_t    i_set,
  input  logic [7:0]           i_rb_addr,
  output ddc_pkg::chain_cfg_t  o_cfg,
  output logic [63:0]          o_rb_data
);

  ddc_pkg::chain_cfg_t cfg_q;
  logic                hit;

  // Only writes aimed at this channel
  assign hit = i_set_stb && (i_set.chan == 1'(CHAIN_IDX));

  ////////////////////
  // Write decode
  ////////////////////
  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      cfg_q.freq  <= 32'd0;
      cfg_q.scale <= ddc_pkg::SCALE_UNITY;
      cfg_q.decim <= 8'd1;
    end else if (hit) begin
      case (i_set.addr)
        ddc_pkg::SR_FREQ_ADDR: begin
          cfg_q.freq <= i_set.data;
        end
        ddc_pkg::SR_SCALE_IQ_ADDR: begin
          cfg_q.scale <= i_set.data[ddc_pkg::SCALE_W-1:0];
        end
        ddc_pkg::SR_DECIM_ADDR: begin
          // A zero rate means no decimation
          cfg_q.decim <= (i_set.data[7:0] == 8'd0) ? 8'd1 : i_set.data[7:0];
        end
        default: begin
        end
      endcase
    end
  end

  assign o_cfg = cfg_q;

  ////////////////////
  // Readback select
  ////////////////////
  always_comb begin
    case (i_rb_addr)
      ddc_pkg::RB_COMPAT_NUM:    o_rb_data = ddc_pkg::COMPAT_NUM;
      ddc_pkg::RB_CIC_MAX_DECIM: o_rb_data = 64'(ddc_pkg::CIC_MAX_DECIM);
      ddc_pkg::RB_FREQ:          o_rb_data = {32'd0, cfg_q.freq};
      ddc_pkg::RB_DECIM:         o_rb_data = {56'd0, cfg_q.decim};
      default:                   o_rb_data = ddc_pkg::RB_DEFAULT;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/iq_scaler.sv
// Saturating IQ gain stage
`timescale 1ns/1ns
`default_nettype none

module iq_scaler (
  input  logic                               i_ce_clk,
  input  logic                               i_rst,
  input  logic signed [ddc_pkg::SCALE_W-1:0] i_scale,
  input  logic                               i_valid,
  input  ddc_pkg::acc_beat_t                 i_beat,
  output logic                               o_ready,
  output logic                               o_valid,
  output ddc_pkg::iq_beat_t                  o_beat,
  input  logic                               i_ready
);

  logic signed [ddc_pkg::PROD_W-1:0] prod_i;
  logic signed [ddc_pkg::PROD_W-1:0] prod_q;
  ddc_pkg::iq_beat_t                 scaled;

  // Clip to the 16-bit signed range
  function automatic logic signed [15:0] sat16(input logic signed [ddc_pkg::PROD_W-1:0] x);
    if (x > ddc_pkg::PROD_W'(ddc_pkg::SAMPLE_MAX)) begin
      sat16 = ddc_pkg::SAMPLE_MAX;
    end else if (x < -(ddc_pkg::PROD_W'(32768))) begin
      sat16 = ddc_pkg::SAMPLE_MIN;
    end else begin
      sat16 = x[15:0];
    end
  endfunction

  assign prod_i = ($signed(i_beat.s.i) * $signed(i_scale)) >>> ddc_pkg::SCALE_SHIFT;
  assign prod_q = ($signed(i_beat.s.q) * $signed(i_scale)) >>> ddc_pkg::SCALE_SHIFT;

  assign scaled.s.i  = sat16(prod_i);
  assign scaled.s.q  = sat16(prod_q);
  assign scaled.last = i_beat.last;

  stream_reg #(.T(ddc_pkg::iq_beat_t)) u_out_reg (
    .i_ce_clk (i_ce_clk),
    .i_rst    (i_rst),
    .i_valid  (i_valid),
    .i_data   (scaled),
    .o_ready  (o_ready),
    .o_valid  (o_valid),
    .o_data   (o_beat),
    .i_ready  (i_ready)
  );

endmodule

`default_nettype wire

// File: hw/quadrant_mixer.sv
// Coarse quadrant mixer
`timescale 1ns/1ns
`default_nettype none

module quadrant_mixer (
  input  logic              i_ce_clk,
  input  logic              i_rst,
  input  logic [31:0]       i_freq,
  input  logic              i_valid,
  input  ddc_pkg::iq_beat_t i_beat,
  output logic              o_ready,
  output logic              o_valid,
  output ddc_pkg::iq_beat_t o_beat,
  input  logic              i_ready
);

  logic [31:0]       phase_q;
  logic [1:0]        quad;
  logic              accept;
  ddc_pkg::iq_beat_t rot;

  // Two's complement negate that clips at full scale
  function automatic logic signed [15:0] neg_sat(input logic signed [15:0] x);
    neg_sat = (x == ddc_pkg::SAMPLE_MIN) ? ddc_pkg::SAMPLE_MAX : -x;
  endfunction

  assign quad   = phase_q[31:30];
  assign accept = i_valid & o_ready;

  always_comb begin
    rot.last = i_beat.last;
    case (quad)
      2'd0: begin
        rot.s.i = i_beat.s.i;
        rot.s.q = i_beat.s.q;
      end
      2'd1: begin
        rot.s.i = neg_sat(i_beat.s.q);
        rot.s.q = i_beat.s.i;
      end
      2'd2: begin
        rot.s.i = neg_sat(i_beat.s.i);
        rot.s.q = neg_sat(i_beat.s.q);
      end
      default: begin
        rot.s.i = i_beat.s.q;
        rot.s.q = neg_sat(i_beat.s.i);
      end
    endcase
  end

  // Phase restarts with each burst
  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      phase_q <= 32'd0;
    end else if (accept) begin
      phase_q <= i_beat.last ? 32'd0 : phase_q + i_freq;
    end
  end

  stream_reg #(.T(ddc_pkg::iq_beat_t)) u_out_reg (
    .i_ce_clk (i_ce_clk),
    .i_rst    (i_rst),
    .i_valid  (i_valid),
    .i_data   (rot),
    .o_ready  (o_ready),
    .o_valid  (o_valid),
    .o_data   (o_beat),
    .i_ready  (i_ready)
  );

endmodule

`default_nettype wire

// File: hw/stream_reg.sv
// Valid/ready pipeline register
`timescale 1ns/1ns
`default_nettype none

module stream_reg #(
  parameter type T = logic [31:0]
) (
  input  logic i_ce_clk,
  input  logic i_rst,
  input  logic i_valid,
  input  T     i_data,
  output logic o_ready,
  output logic o_valid,
  output T     o_data,
  input  logic i_ready
);

  T     data_q;
  logic valid_q;
  logic run_q;

  // Accept while empty or while the held beat leaves
  assign o_ready = run_q & (~valid_q | i_ready);
  assign o_valid = valid_q;
  assign o_data  = data_q;

  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      run_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (o_ready) begin
        valid_q <= i_valid;
      end
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (o_ready && i_valid) begin
      data_q <= i_data;
    end
  end

  a_hold_stable : assert property (@(posedge i_ce_clk) disable iff (i_rst)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_data)));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile and run the DDC testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_ddc_block -f vlog.f \
  && ./obj_dir/Vtb_ddc_block > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q -x "sim passed" sim.log && exit 0 || exit 1

// File: sim/ddc_golden.txt
# W chan addr data | R chan addr expected_readback | I/O chan i q last
# All fields hex; I is a channel input beat, O the expected output beat
R 0 00 0000000200000000
R 1 02 00000000000000ff
R 0 07 0badc0de0badc0de
R 1 04 0000000000000001
I 0 04d2 fffb 0
I 0 8000 7fff 0
I 0 0001 ffff 1
I 1 0100 0200 1
O 0 04d2 fffb 0
O 0 8000 7fff 0
O 0 0001 ffff 1
O 1 0100 0200 1
W 0 84 40000000
R 0 03 0000000040000000
I 0 0064 00c8 0
I 0 012c fe70 0
I 0 8000 0005 0
I 0 0007 8000 0
I 0 000b 0016 1
I 0 ffff 0002 0
I 0 0003 0004 1
O 0 0064 00c8 0
O 0 0190 012c 0
O 0 7fff fffb 0
O 0 8000 fff9 0
O 0 000b 0016 1
O 0 ffff 0002 0
O 0 fffc 0003 1
W 0 84 00000000
W 1 86 00000004
R 1 04 0000000000000004
I 1 000a ffff 0
I 1 0014 fffe 0
I 1 001e fffd 0
I 1 0028 fffc 0
I 1 03e8 0005 0
I 1 07d0 0006 1
O 1 0064 fff6 0
O 1 0bb8 000b 1
W 0 85 00004000
I 0 03e8 fc18 0
I 0 fffd 0003 1
O 0 01f4 fe0c 0
O 0 fffe 0001 1
W 0 85 00010000
I 0 4e20 b1e0 0
I 0 04d2 fff9 1
O 0 7fff 8000 0
O 0 09a4 fff2 1
W 1 86 000000ff
I 1 7530 8ad0 0
I 1 7530 8ad0 0
I 1 7530 8ad0 1
O 1 7fff 8000 1
W 0 85 00008000
W 0 84 40000000
W 0 86 00000002
W 1 86 00000001
W 1 84 80000000
W 1 85 00004000
I 0 0064 0032 0
I 0 000a 0014 0
I 0 0005 0007 0
I 0 03e8 0003 1
I 0 0007 0008 0
I 0 0009 000a 1
I 1 00c8 ff9c 0
I 1 0190 003c 0
I 1 fff9 0009 0
I 1 0001 ffff 1
O 0 0050 003c 0
O 0 fffe fc11 1
O 0 fffd 0011 1
O 1 0064 ffce 0
O 1 ff38 ffe2 0
O 1 fffc 0004 0
O 1 ffff 0000 1
R 1 03 0000000080000000
R 0 04 0000000000000002

// File: sim/tb_ddc_block.sv
// DDC block testbench
`timescale 1ns/1ns
`default_nettype none

module tb_ddc_block;

  localparam int NCH      = ddc_pkg::NUM_CHAINS;
  localparam int MAX_WAIT = 4000;

  logic                        clk;
  logic                        rst;
  logic                        set_stb;
  ddc_pkg::setting_t           set_word;
  logic                        rb_stb;
  ddc_pkg::rb_req_t            rb_req;
  logic                        rb_valid;
  logic [63:0]                 rb_data;
  logic [NCH-1:0]              in_valid;
  ddc_pkg::iq_beat_t [NCH-1:0] in_beat;
  logic [NCH-1:0]              in_ready;
  logic [NCH-1:0]              out_valid;
  ddc_pkg::iq_beat_t [NCH-1:0] out_beat;
  logic [NCH-1:0]              out_ready;

  // Pending input beats and expected output beats per channel
  ddc_pkg::iq_beat_t in_q[NCH][$];
  ddc_pkg::iq_beat_t exp_q[NCH][$];
  int                value_errors;
  int                other_errors;
  bit                aborted;

  ddc_block u_ddc_block (
    .i_ce_clk    (clk),
    .i_rst       (rst),
    .i_set_stb   (set_stb),
    .i_set       (set_word),
    .i_rb_stb    (rb_stb),
    .i_rb_req    (rb_req),
    .o_rb_valid  (rb_valid),
    .o_rb_data   (rb_data),
    .i_in_valid  (in_valid),
    .i_in_beat   (in_beat),
    .o_in_ready  (in_ready),
    .o_out_valid (out_valid),
    .o_out_beat  (out_beat),
    .i_out_ready (out_ready)
  );

  always #50 clk = ~clk;

  ////////////////////
  // Output checker
  ////////////////////
  always @(negedge clk) begin
    ddc_pkg::iq_beat_t want;
    if (!rst) begin
      for (int c = 0; c < NCH; c++) begin
        if (out_valid[c] && out_ready[c]) begin
          assert (exp_q[c].size() > 0) else begin
            other_errors++;
            $display("Channel %0d sent an output beat that was not expected at %0t",
                     c, $time);
          end
          if (exp_q[c].size() > 0) begin
            want = exp_q[c].pop_front();
            assert (out_beat[c] == want) else begin
              value_errors++;
              $display("[ERROR] %0t o_out_beat[%0d] expected %h got %h",
                       $time, c, want, out_beat[c]);
            end
          end
        end
      end
    end
  end

  task automatic write_setting(input logic chan, input logic [7:0] addr,
                               input logic [31:0] data);
    @(posedge clk);
    #1;
    set_stb       = 1'b1;
    set_word.chan = chan;
    set_word.addr = addr;
    set_word.data = data;
    @(posedge clk);
    #1;
    set_stb = 1'b0;
  endtask

  // Answer is due exactly one cycle after the strobe
  task automatic check_readback(input logic chan, input logic [7:0] addr,
                                input logic [63:0] want);
    @(posedge clk);
    #1;
    rb_stb      = 1'b1;
    rb_req.chan = chan;
    rb_req.addr = addr;
    @(negedge clk);
    assert (!rb_valid) else begin
      other_errors++;
      $display("Readback valid rose in the strobe cycle at %0t", $time);
    end
    @(posedge clk);
    #1;
    rb_stb = 1'b0;
    @(negedge clk);
    assert (rb_valid) else begin
      other_errors++;
      $display("Readback valid missing one cycle after the strobe at %0t", $time);
    end
    assert (rb_data == want) else begin
      value_errors++;
      $display("[ERROR] %0t o_rb_data expected %h got %h", $time, want, rb_data);
    end
  endtask

  // Push queued beats through both channels until all outputs are seen
  task automatic run_traffic();
    int             waited;
    bit             busy;
    logic [NCH-1:0] took;
    waited = 0;
    busy   = 1'b1;
    while (busy && !aborted) begin
      @(negedge clk);
      took = in_valid & in_ready;
      @(posedge clk);
      #1;
      for (int c = 0; c < NCH; c++) begin
        if (took[c]) begin
          void'(in_q[c].pop_front());
          in_valid[c] = 1'b0;
        end
        if (!in_valid[c] && in_q[c].size() > 0 && ($urandom % 4) != 0) begin
          in_valid[c] = 1'b1;
          in_beat[c]  = in_q[c][0];
        end
        out_ready[c] = ($urandom % 4) != 0;
      end
      busy = 1'b0;
      for (int c = 0; c < NCH; c++) begin
        if (in_q[c].size() > 0 || exp_q[c].size() > 0) begin
          busy = 1'b1;
        end
      end
      waited++;
      if (busy && waited > MAX_WAIT) begin
        other_errors++;
        aborted = 1'b1;
        $display("Timeout while waiting for the channels to drain at %0t", $time);
      end
    end
    out_ready = '1;
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    int                fd;
    int                n;
    int                ch;
    string             line;
    logic [7:0]        kind;
    logic [63:0]       f1;
    logic [63:0]       f2;
    logic [63:0]       f3;
    logic [63:0]       f4;
    ddc_pkg::iq_beat_t beat;

    void'($urandom(6139));
    clk          = 1'b0;
    rst          = 1'b1;
    set_stb      = 1'b0;
    set_word     = '0;
    rb_stb       = 1'b0;
    rb_req       = '0;
    in_valid     = '0;
    in_beat      = '0;
    out_ready    = '1;
    value_errors = 0;
    other_errors = 0;
    aborted      = 1'b0;

    for (int k = 0; k < 16; k++) begin
      @(posedge clk);
      #1;
      assert (in_ready == '0 && out_valid == '0 && !rb_valid) else begin
        other_errors++;
        $display("Outputs were active during reset at %0t", $time);
      end
    end
    rst = 1'b0;

    fd = $fopen("sim/ddc_golden.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open sim/ddc_golden.txt");
    end else begin
      while (!aborted && $fgets(line, fd) != 0) begin
        kind = 8'h00;
        n    = $sscanf(line, "%c %h %h %h %h", kind, f1, f2, f3, f4);
        ch   = int'(f1[0]);
        case (kind)
          "W": begin
            run_traffic();
            write_setting(f1[0], f2[7:0], f3[31:0]);
          end
          "R": begin
            run_traffic();
            check_readback(f1[0], f2[7:0], f3);
          end
          "I", "O": begin
            if (n != 5) begin
              other_errors++;
              $display("Malformed beat line in the golden file: %s", line);
            end else begin
              beat.s.i  = f2[15:0];
              beat.s.q  = f3[15:0];
              beat.last = f4[0];
              if (kind == "I") begin
                in_q[ch].push_back(beat);
              end else begin
                exp_q[ch].push_back(beat);
              end
            end
          end
          default: begin
          end
        endcase
      end
      $fclose(fd);
    end
    run_traffic();

    $display("Finished with %0d value errors and %0d other errors",
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
hw/ddc_pkg.sv
hw/stream_reg.sv
hw/ddc_settings.sv
hw/quadrant_mixer.sv
hw/cic_decimator.sv
hw/iq_scaler.sv
hw/ddc_chain.sv
hw/ddc_block.sv
sim/tb_ddc_block.sv
